// ==== Makefile ====
SIM = obj_dir/Vexec_unit_tb

all: run

$(SIM): sources.f $(wildcard design/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert -j 0 --top-module exec_unit_tb -f sources.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q '^\*\*\* PASSED \*\*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== design/alu.sv ====
/*
 * Integer ALU
 * Single-cycle add, shift, compare, logic and multiply unit with a
 * zero flag; divide codes are left to the serial divider
 */
`timescale 1ns/1ps

module alu (
    input  logic [exec_pkg::XLEN-1:0] i_data1,
    input  logic [exec_pkg::XLEN-1:0] i_data2,
    input  exec_pkg::alu_op_e         i_alu_op,
    output logic [exec_pkg::XLEN-1:0] o_result,
    output logic                      o_zero
);
    logic [2*exec_pkg::XLEN-1:0] prod_ss;  // signed x signed
    logic [2*exec_pkg::XLEN-1:0] prod_uu;  // unsigned x unsigned
    logic [2*exec_pkg::XLEN+1:0] prod_su;  // signed x unsigned, one guard bit each
    logic [4:0]                  shamt;

    assign shamt   = i_data2[4:0];
    assign prod_ss = $signed(i_data1) * $signed(i_data2);
    assign prod_uu = i_data1 * i_data2;
    assign prod_su = $signed({i_data1[exec_pkg::XLEN-1], i_data1}) *
                     $signed({1'b0, i_data2});

    always_comb begin
        case (i_alu_op)
            exec_pkg::ADD:    o_result = i_data1 + i_data2;
            exec_pkg::SUB:    o_result = i_data1 - i_data2;
            exec_pkg::SLL:    o_result = i_data1 << shamt;
            exec_pkg::SLT:    o_result = {31'b0, $signed(i_data1) < $signed(i_data2)};
            exec_pkg::SLTU:   o_result = {31'b0, i_data1 < i_data2};
            exec_pkg::XOR:    o_result = i_data1 ^ i_data2;
            exec_pkg::SRL:    o_result = i_data1 >> shamt;
            exec_pkg::SRA:    o_result = $signed(i_data1) >>> shamt;
            exec_pkg::OR:     o_result = i_data1 | i_data2;
            exec_pkg::AND:    o_result = i_data1 & i_data2;
            exec_pkg::MUL:    o_result = prod_uu[exec_pkg::XLEN-1:0];  // Low half is sign-agnostic
            exec_pkg::MULH:   o_result = prod_ss[2*exec_pkg::XLEN-1:exec_pkg::XLEN];
            exec_pkg::MULHSU: o_result = prod_su[2*exec_pkg::XLEN-1:exec_pkg::XLEN];
            exec_pkg::MULHU:  o_result = prod_uu[2*exec_pkg::XLEN-1:exec_pkg::XLEN];
            default:          o_result = '0;  // Divide codes
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

// ==== design/exec_pkg.sv ====
/*
 * Execute cluster package
 * Widths, operation and opcode encodings, and the structs passed
 * between the decoder, the producers and the writeback arbiter
 */
package exec_pkg;

    localparam int XLEN   = 32;  // One data word
    localparam int REG_AW = 5;   // 32 architectural registers

    // Operation encoding shared by the ALU and the divider
    typedef enum logic [4:0] {
        ADD    = 5'b00000,
        SUB    = 5'b00001,
        SLL    = 5'b00010,
        SLT    = 5'b00011,
        SLTU   = 5'b00100,
        XOR    = 5'b00101,
        SRL    = 5'b00110,
        SRA    = 5'b00111,
        OR     = 5'b01000,
        AND    = 5'b01001,
        MUL    = 5'b01010,
        MULH   = 5'b01011,
        MULHSU = 5'b01100,
        MULHU  = 5'b01101,
        DIV    = 5'b01110,
        DIVU   = 5'b01111,
        REM    = 5'b10000,
        REMU   = 5'b10001
    } alu_op_e;

    // Major opcodes handled here
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011
    } opcode_e;

    typedef struct packed {
        alu_op_e             op;
        logic [REG_AW-1:0]   rs1;
        logic [REG_AW-1:0]   rs2;
        logic [REG_AW-1:0]   rd;
        logic                use_imm;  // Operand 2 from the immediate
        logic [XLEN-1:0]     imm;
        logic                is_div;   // Goes to the divider
        logic                wb_en;    // Low for rd == x0
        logic                illegal;
    } exec_cmd_t;

    typedef struct packed {
        logic                valid;
        logic [REG_AW-1:0]   rd;
        logic [XLEN-1:0]     data;
        logic                zero;
    } wb_req_t;

endpackage

// ==== design/exec_unit.sv ====
/*
 * Integer execute cluster
 * Decoder, register file, ALU and serial divider sharing one
 * write port through the writeback arbiter
 */
`timescale 1ns/1ps

module exec_unit (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_valid,
    input  logic [31:0]                 i_instr,
    output logic                        o_wb_valid,
    output logic [exec_pkg::REG_AW-1:0] o_wb_rd,
    output logic [exec_pkg::XLEN-1:0]   o_wb_data,
    output logic                        o_wb_zero,
    output logic                        o_div_busy,
    output logic                        o_illegal
);
    exec_pkg::exec_cmd_t         cmd;
    exec_pkg::wb_req_t           alu_req;
    exec_pkg::wb_req_t           div_req;
    exec_pkg::wb_req_t           wb;
    logic [exec_pkg::XLEN-1:0]   rs1_data;
    logic [exec_pkg::XLEN-1:0]   rs2_data;
    logic [exec_pkg::XLEN-1:0]   operand2;
    logic [exec_pkg::XLEN-1:0]   alu_result;
    logic                        alu_zero;
    logic                        div_start;
    logic                        div_grant;
    logic                        wr_en;
    logic [exec_pkg::REG_AW-1:0] wr_addr;
    logic [exec_pkg::XLEN-1:0]   wr_data;
    logic                        illegal_q;

    instr_decoder u_decoder (.i_instr(i_instr), .o_cmd(cmd));

    reg_file u_reg_file (
        .i_clock(i_clock), .i_reset(i_reset),
        .i_rs1(cmd.rs1), .i_rs2(cmd.rs2),
        .i_wr_addr(wr_addr), .i_wr_en(wr_en), .i_wr_data(wr_data),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
    );

    assign operand2 = cmd.use_imm ? cmd.imm : rs2_data;

    alu u_alu (
        .i_data1(rs1_data), .i_data2(operand2), .i_alu_op(cmd.op),
        .o_result(alu_result), .o_zero(alu_zero)
    );

    always_comb begin
        alu_req.valid = i_valid && !cmd.is_div && cmd.wb_en;
        alu_req.rd    = cmd.rd;
        alu_req.data  = alu_result;
        alu_req.zero  = alu_zero;
    end

    assign div_start = i_valid && cmd.is_div && cmd.wb_en;  // Divide into x0 is dropped

    serial_divider u_divider (
        .i_clock(i_clock), .i_reset(i_reset), .i_start(div_start),
        .i_op(cmd.op), .i_rd(cmd.rd),
        .i_dividend(rs1_data), .i_divisor(rs2_data),
        .i_grant(div_grant), .o_req(div_req), .o_busy(o_div_busy)
    );

    wb_arbiter u_arbiter (
        .i_clock(i_clock), .i_reset(i_reset),
        .i_alu_req(alu_req), .i_div_req(div_req), .o_div_grant(div_grant),
        .o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_data(wr_data), .o_wb(wb)
    );

    always_ff @(posedge i_clock) begin
        if (i_reset)
            illegal_q <= 1'b0;
        else
            illegal_q <= i_valid && cmd.illegal;  // Lines up with the writeback timing
    end

    assign o_wb_valid = wb.valid;
    assign o_wb_rd    = wb.rd;
    assign o_wb_data  = wb.data;
    assign o_wb_zero  = wb.zero;
    assign o_illegal  = illegal_q;

endmodule

// ==== design/instr_decoder.sv ====
/*
 * Instruction decoder
 * Maps OP and OP-IMM encodings, M extension included, onto an
 * execute command with operand selects and the I-type immediate
 */
`timescale 1ns/1ps

module instr_decoder (
    input  logic [31:0]         i_instr,
    output exec_pkg::exec_cmd_t o_cmd
);
    logic [6:0] funct7;
    logic [2:0] funct3;

    assign funct7 = i_instr[31:25];
    assign funct3 = i_instr[14:12];

    always_comb begin
        o_cmd     = '0;
        o_cmd.op  = exec_pkg::ADD;
        o_cmd.rs1 = i_instr[19:15];
        o_cmd.rs2 = i_instr[24:20];
        o_cmd.rd  = i_instr[11:7];
        o_cmd.imm = {{20{i_instr[31]}}, i_instr[31:20]};  // I-type, sign extended

        case (i_instr[6:0])
            exec_pkg::OP: begin
                case (funct7)
                    7'b0000000: begin
                        case (funct3)
                            3'b000:  o_cmd.op = exec_pkg::ADD;
                            3'b001:  o_cmd.op = exec_pkg::SLL;
                            3'b010:  o_cmd.op = exec_pkg::SLT;
                            3'b011:  o_cmd.op = exec_pkg::SLTU;
                            3'b100:  o_cmd.op = exec_pkg::XOR;
                            3'b101:  o_cmd.op = exec_pkg::SRL;
                            3'b110:  o_cmd.op = exec_pkg::OR;
                            default: o_cmd.op = exec_pkg::AND;
                        endcase
                    end
                    7'b0100000: begin
                        case (funct3)
                            3'b000:  o_cmd.op = exec_pkg::SUB;
                            3'b101:  o_cmd.op = exec_pkg::SRA;
                            default: o_cmd.illegal = 1'b1;
                        endcase
                    end
                    7'b0000001: begin  // M extension
                        case (funct3)
                            3'b000:  o_cmd.op = exec_pkg::MUL;
                            3'b001:  o_cmd.op = exec_pkg::MULH;
                            3'b010:  o_cmd.op = exec_pkg::MULHSU;
                            3'b011:  o_cmd.op = exec_pkg::MULHU;
                            3'b100:  o_cmd.op = exec_pkg::DIV;
                            3'b101:  o_cmd.op = exec_pkg::DIVU;
                            3'b110:  o_cmd.op = exec_pkg::REM;
                            default: o_cmd.op = exec_pkg::REMU;
                        endcase
                    end
                    default: o_cmd.illegal = 1'b1;
                endcase
            end
            exec_pkg::OP_IMM: begin
                o_cmd.use_imm = 1'b1;
                case (funct3)
                    3'b000: o_cmd.op = exec_pkg::ADD;
                    3'b010: o_cmd.op = exec_pkg::SLT;
                    3'b011: o_cmd.op = exec_pkg::SLTU;
                    3'b100: o_cmd.op = exec_pkg::XOR;
                    3'b110: o_cmd.op = exec_pkg::OR;
                    3'b111: o_cmd.op = exec_pkg::AND;
                    default: begin
                        // Shifts take only the shamt field
                        o_cmd.imm = {27'b0, i_instr[24:20]};
                        if (funct3 == 3'b001 && funct7 == 7'b0000000)
                            o_cmd.op = exec_pkg::SLL;
                        else if (funct3 == 3'b101 && funct7 == 7'b0000000)
                            o_cmd.op = exec_pkg::SRL;
                        else if (funct3 == 3'b101 && funct7 == 7'b0100000)
                            o_cmd.op = exec_pkg::SRA;
                        else
                            o_cmd.illegal = 1'b1;
                    end
                endcase
            end
            default: o_cmd.illegal = 1'b1;
        endcase

        o_cmd.is_div = (o_cmd.op == exec_pkg::DIV) || (o_cmd.op == exec_pkg::DIVU) ||
                       (o_cmd.op == exec_pkg::REM) || (o_cmd.op == exec_pkg::REMU);
        o_cmd.wb_en  = (o_cmd.rd != '0) && !o_cmd.illegal;
    end

endmodule

// ==== design/reg_file.sv ====
/*
 * Register file
 * 32 x 32 with two asynchronous read ports and one write port;
 * x0 always reads zero
 */
`timescale 1ns/1ps

module reg_file (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic [exec_pkg::REG_AW-1:0] i_rs1,
    input  logic [exec_pkg::REG_AW-1:0] i_rs2,
    input  logic [exec_pkg::REG_AW-1:0] i_wr_addr,
    input  logic                        i_wr_en,
    input  logic [exec_pkg::XLEN-1:0]   i_wr_data,
    output logic [exec_pkg::XLEN-1:0]   o_rs1_data,
    output logic [exec_pkg::XLEN-1:0]   o_rs2_data
);
    logic [exec_pkg::XLEN-1:0] regs [2**exec_pkg::REG_AW];

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < 2**exec_pkg::REG_AW; i++)
                regs[i] <= '0;
        end else if (i_wr_en && i_wr_addr != '0) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// ==== design/serial_divider.sv ====
/*
 * Serial divider
 * Radix-2 restoring divider, one quotient bit per cycle, for DIV,
 * DIVU, REM and REMU; holds its writeback request until granted
 */
`timescale 1ns/1ps

module serial_divider (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_start,
    input  exec_pkg::alu_op_e           i_op,
    input  logic [exec_pkg::REG_AW-1:0] i_rd,
    input  logic [exec_pkg::XLEN-1:0]   i_dividend,
    input  logic [exec_pkg::XLEN-1:0]   i_divisor,
    input  logic                        i_grant,
    output exec_pkg::wb_req_t           o_req,
    output logic                        o_busy
);
    typedef enum logic [1:0] {IDLE, RUN, DONE} div_state_e;

    div_state_e                  state;
    logic [5:0]                  count;      // Iterations done
    logic [exec_pkg::XLEN-1:0]   quo_q;      // Dividend shifts out, quotient shifts in
    logic [exec_pkg::XLEN-1:0]   rem_q;
    logic [exec_pkg::XLEN-1:0]   dvs_q;      // Divisor magnitude
    logic [exec_pkg::XLEN-1:0]   result_q;
    logic [exec_pkg::REG_AW-1:0] rd_q;
    logic                        want_rem_q;
    logic                        neg_quo_q;
    logic                        neg_rem_q;
    logic                        div_zero_q;

    logic                        is_signed;
    logic                        a_neg;
    logic                        b_neg;
    logic [exec_pkg::XLEN-1:0]   a_mag;
    logic [exec_pkg::XLEN-1:0]   b_mag;
    logic [exec_pkg::XLEN:0]     shifted;
    logic [exec_pkg::XLEN:0]     diff;
    logic [exec_pkg::XLEN-1:0]   quo_fix;
    logic [exec_pkg::XLEN-1:0]   rem_fix;

    assign is_signed = (i_op == exec_pkg::DIV) || (i_op == exec_pkg::REM);
    assign a_neg     = is_signed && i_dividend[exec_pkg::XLEN-1];
    assign b_neg     = is_signed && i_divisor[exec_pkg::XLEN-1];
    assign a_mag     = a_neg ? -i_dividend : i_dividend;
    assign b_mag     = b_neg ? -i_divisor : i_divisor;

    // One restoring step
    assign shifted = {rem_q, quo_q[exec_pkg::XLEN-1]};
    assign diff    = shifted - {1'b0, dvs_q};

    // Overflow (min / -1) already comes out as dividend and zero here
    assign quo_fix = div_zero_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
    assign rem_fix = neg_rem_q ? -rem_q : rem_q;  // Zero divisor leaves the dividend

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state <= IDLE;
            count <= '0;
        end else begin
            case (state)
                IDLE: if (i_start) begin
                    state <= RUN;
                    count <= '0;
                end
                RUN: begin
                    if (count == exec_pkg::XLEN)
                        state <= DONE;  // Result registered on this edge
                    else
                        count <= count + 6'd1;
                end
                default: if (i_grant) state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == IDLE && i_start) begin
            quo_q      <= a_mag;
            rem_q      <= '0;
            dvs_q      <= b_mag;
            rd_q       <= i_rd;
            want_rem_q <= (i_op == exec_pkg::REM) || (i_op == exec_pkg::REMU);
            neg_quo_q  <= a_neg ^ b_neg;
            neg_rem_q  <= a_neg;  // Remainder takes the dividend's sign
            div_zero_q <= (i_divisor == '0);
        end else if (state == RUN) begin
            if (count != exec_pkg::XLEN) begin
                quo_q <= {quo_q[exec_pkg::XLEN-2:0], ~diff[exec_pkg::XLEN]};
                rem_q <= diff[exec_pkg::XLEN] ? shifted[exec_pkg::XLEN-1:0]
                                              : diff[exec_pkg::XLEN-1:0];
            end else begin
                result_q <= want_rem_q ? rem_fix : quo_fix;
            end
        end
    end

    always_comb begin
        o_req.valid = (state == DONE);
        o_req.rd    = rd_q;
        o_req.data  = result_q;
        o_req.zero  = (result_q == '0);
    end

    assign o_busy = (state != IDLE);

endmodule

// ==== design/wb_arbiter.sv ====
/*
 * Writeback arbiter
 * Shares the single register write port between the ALU and the
 * divider, ALU first, and registers the winner for the outputs
 */
`timescale 1ns/1ps

module wb_arbiter (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  exec_pkg::wb_req_t           i_alu_req,
    input  exec_pkg::wb_req_t           i_div_req,
    output logic                        o_div_grant,
    output logic                        o_wr_en,
    output logic [exec_pkg::REG_AW-1:0] o_wr_addr,
    output logic [exec_pkg::XLEN-1:0]   o_wr_data,
    output exec_pkg::wb_req_t           o_wb
);
    exec_pkg::wb_req_t sel;
    exec_pkg::wb_req_t wb_q;
    logic              wb_valid_q;

    assign o_div_grant = i_div_req.valid && !i_alu_req.valid;  // Divider waits on any ALU result
    assign sel         = i_alu_req.valid ? i_alu_req : i_div_req;

    assign o_wr_en   = sel.valid;
    assign o_wr_addr = sel.rd;
    assign o_wr_data = sel.data;

    always_ff @(posedge i_clock) begin
        if (i_reset)
            wb_valid_q <= 1'b0;
        else
            wb_valid_q <= sel.valid;
    end

    always_ff @(posedge i_clock) begin
        if (sel.valid)
            wb_q <= sel;
    end

    always_comb begin
        o_wb       = wb_q;
        o_wb.valid = wb_valid_q;  // One-cycle strobe
    end

endmodule

// ==== sources.f ====
design/exec_pkg.sv
design/instr_decoder.sv
design/alu.sv
design/serial_divider.sv
design/reg_file.sv
design/wb_arbiter.sv
design/exec_unit.sv
test/exec_unit_tb.sv

// ==== test/exec_unit_tb.sv ====
/*
 * Execute cluster testbench
 * Seeded random OP, OP-IMM and divide traffic checked against a
 * shadow register model, plus reset, x0, overlap and illegal cases
 */
`timescale 1ns/1ps

module exec_unit_tb;
    localparam int         CLK_PERIOD    = 100;
    localparam int         SEED          = 69;
    localparam int         N_RESET_READS = 8;
    localparam int         N_ALU_RANDOM  = 200;
    localparam int         N_RD_ZERO     = 10;
    localparam int         N_DIV_RANDOM  = 8;
    localparam int         N_B2B         = 45;
    // Fixed setup, special divides and illegal encodings add about 30
    localparam int         TOTAL_INSTR   = N_RESET_READS + 31 + N_ALU_RANDOM + N_RD_ZERO +
                                           N_DIV_RANDOM + N_B2B + 30;
    localparam logic [6:0] OPC_REG       = 7'b0110011;
    localparam logic [6:0] OPC_IMM       = 7'b0010011;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_exp_t;

    logic        i_clock;
    logic        i_reset;
    logic        i_valid;
    logic [31:0] i_instr;
    logic        o_wb_valid;
    logic [4:0]  o_wb_rd;
    logic [31:0] o_wb_data;
    logic        o_wb_zero;
    logic        o_div_busy;
    logic        o_illegal;

    logic [31:0] shadow [32];  // Architectural state as the model sees it
    wb_exp_t     alu_exp;      // Due at the next check
    wb_exp_t     div_exp;      // Outstanding divide
    logic        ill_exp;
    int          cycle = 0;
    int          div_issue_edge = 0;
    int          errors = 0;
    int          test_start_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    exec_unit u_exec_unit (
        .i_clock(i_clock), .i_reset(i_reset), .i_valid(i_valid), .i_instr(i_instr),
        .o_wb_valid(o_wb_valid), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data),
        .o_wb_zero(o_wb_zero), .o_div_busy(o_div_busy), .o_illegal(o_illegal)
    );

    initial begin
        i_clock = 1'b0;
        forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
    end

    always @(posedge i_clock) cycle <= cycle + 1;

    task automatic log_error(input string msg);
        errors++;
        $display("** Error @ %0t ns: %s", $time, msg);
    endtask

    a_reset_quiet: assert property (@(negedge i_clock)
        (i_reset && cycle > 0) |-> (!o_wb_valid && !o_div_busy && !o_illegal))
        else log_error("outputs active during reset");
    a_busy_drop: assert property (@(negedge i_clock) disable iff (i_reset)
        $fell(o_div_busy) |-> o_wb_valid)
        else log_error("o_div_busy fell without a writeback");
    a_illegal_no_wb: assert property (@(negedge i_clock) disable iff (i_reset)
        o_illegal |-> !o_wb_valid)
        else log_error("writeback together with o_illegal");
    a_illegal_pulse: assert property (@(negedge i_clock) disable iff (i_reset)
        o_illegal |-> !$past(o_illegal))
        else log_error("o_illegal held longer than one cycle");

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_REG};
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1);
        return {imm, rs1, f3, rd, OPC_IMM};
    endfunction

    function automatic logic is_legal(input logic [31:0] instr);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = instr[14:12];
        f7 = instr[31:25];
        if (instr[6:0] == OPC_REG)
            return f7 == 7'h00 || f7 == 7'h01 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        if (instr[6:0] == OPC_IMM) begin
            if (f3 == 3'd1)
                return f7 == 7'h00;
            if (f3 == 3'd5)
                return f7 == 7'h00 || f7 == 7'h20;
            return 1'b1;
        end
        return 1'b0;
    endfunction

    // RV32IM result for one instruction
    function automatic logic [31:0] model_result(input logic [31:0] instr,
                                                 input logic [31:0] a,
                                                 input logic [31:0] rs2_val);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] b;
        logic [4:0]  sh;
        logic [63:0] p;
        f3 = instr[14:12];
        f7 = instr[31:25];
        b  = (instr[6:0] == OPC_IMM) ? {{20{instr[31]}}, instr[31:20]} : rs2_val;
        sh = (instr[6:0] == OPC_IMM) ? instr[24:20] : rs2_val[4:0];
        if (instr[6:0] == OPC_REG && f7 == 7'h01) begin
            case (f3)
                3'd0: begin
                    p = {32'd0, a} * {32'd0, b};
                    return p[31:0];
                end
                3'd1: begin
                    p = {{32{a[31]}}, a} * {{32{b[31]}}, b};  // Mod 2^64 keeps the sign
                    return p[63:32];
                end
                3'd2: begin
                    p = {{32{a[31]}}, a} * {32'd0, b};
                    return p[63:32];
                end
                3'd3: begin
                    p = {32'd0, a} * {32'd0, b};
                    return p[63:32];
                end
                3'd4: begin
                    if (b == 32'd0)
                        return 32'hffff_ffff;
                    if (a == 32'h8000_0000 && b == 32'hffff_ffff)
                        return a;
                    return $signed(a) / $signed(b);
                end
                3'd5: return (b == 32'd0) ? 32'hffff_ffff : a / b;
                3'd6: begin
                    if (b == 32'd0)
                        return a;
                    if (a == 32'h8000_0000 && b == 32'hffff_ffff)
                        return 32'd0;
                    return $signed(a) % $signed(b);
                end
                default: return (b == 32'd0) ? a : a % b;
            endcase
        end
        case (f3)
            3'd0: return (instr[6:0] == OPC_REG && f7[5]) ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: return f7[5] ? ((a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0))
                               : a >> sh;
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Random legal non-divide instruction; avoid keeps one register untouched
    function automatic logic [31:0] random_alu_instr(input logic [4:0] avoid);
        logic [31:0] instr;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        int          kind;
        do begin
            rd   = 5'(1 + $urandom % 31);
            rs1  = 5'($urandom);
            rs2  = 5'($urandom);
            f3   = 3'($urandom);
            kind = int'($urandom % 3);
            if (kind == 0 && (f3 == 3'd1 || f3 == 3'd5)) begin
                f7    = (f3 == 3'd5 && $urandom % 2 == 1) ? 7'h20 : 7'h00;
                instr = encode_i({f7, rs2}, f3, rd, rs1);  // Shift amount in rs2 field
            end else if (kind == 0) begin
                instr = encode_i(12'($urandom), f3, rd, rs1);
            end else if (kind == 1) begin
                f7    = ((f3 == 3'd0 || f3 == 3'd5) && $urandom % 2 == 1) ? 7'h20 : 7'h00;
                instr = encode_r(f7, f3, rd, rs1, rs2);
            end else begin
                instr = encode_r(7'h01, {1'b0, f3[1:0]}, rd, rs1, rs2);  // Multiplies
            end
        end while (avoid != 5'd0 && (rd == avoid || rs1 == avoid || rs2 == avoid));
        return instr;
    endfunction

    // Compare the outputs with what the model expects at this falling edge
    task automatic check_outputs();
        int since;
        since = cycle - div_issue_edge;
        assert (o_illegal == ill_exp)
            else log_error($sformatf("o_illegal=%0b, expected %0b", o_illegal, ill_exp));
        if (alu_exp.valid) begin
            assert (o_wb_valid && o_wb_rd == alu_exp.rd && o_wb_data == alu_exp.data &&
                    o_wb_zero == (alu_exp.data == 32'd0))
                else log_error($sformatf("ALU wb valid=%0b rd=%0d data=%h zero=%0b, exp rd=%0d %h",
                               o_wb_valid, o_wb_rd, o_wb_data, o_wb_zero,
                               alu_exp.rd, alu_exp.data));
        end else if (div_exp.valid && since >= 34) begin
            assert (o_wb_valid && o_wb_rd == div_exp.rd && o_wb_data == div_exp.data &&
                    o_wb_zero == (div_exp.data == 32'd0))
                else log_error($sformatf("divide wb valid=%0b rd=%0d data=%h, exp rd=%0d %h",
                               o_wb_valid, o_wb_rd, o_wb_data, div_exp.rd, div_exp.data));
            div_exp.valid = 1'b0;
        end else begin
            assert (!o_wb_valid)
                else log_error($sformatf("unexpected writeback rd=%0d data=%h",
                               o_wb_rd, o_wb_data));
        end
        assert (o_div_busy == div_exp.valid)
            else log_error($sformatf("o_div_busy=%0b, expected %0b", o_div_busy, div_exp.valid));
        alu_exp.valid = 1'b0;
        ill_exp       = 1'b0;
    endtask

    task automatic issue_instr(input logic [31:0] instr);
        logic [4:0]  rd;
        logic [31:0] result;
        @(negedge i_clock);
        check_outputs();
        i_valid = 1'b1;
        i_instr = instr;
        rd      = instr[11:7];
        if (!is_legal(instr)) begin
            ill_exp = 1'b1;
        end else if (rd != 5'd0) begin
            result     = model_result(instr, shadow[instr[19:15]], shadow[instr[24:20]]);
            shadow[rd] = result;
            if (instr[6:0] == OPC_REG && instr[31:25] == 7'h01 && instr[14]) begin
                div_exp        = '{valid: 1'b1, rd: rd, data: result};
                div_issue_edge = cycle + 1;  // Edge that samples this issue
            end else begin
                alu_exp = '{valid: 1'b1, rd: rd, data: result};
            end
        end
    endtask

    task automatic idle_cycle();
        @(negedge i_clock);
        check_outputs();
        i_valid = 1'b0;
        i_instr = 32'd0;
    endtask

    task automatic drain_divider();
        while (div_exp.valid)
            idle_cycle();
    endtask

    task automatic end_test(input string name);
        idle_cycle();  // Last writeback is checked here
        tests_run++;
        if (errors == test_start_errors) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d error(s)", tests_run, name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    initial begin
        #(TOTAL_INSTR * 40 * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock periods", TOTAL_INSTR * 40);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [4:0] div_rd;
        void'($urandom(SEED));
        i_reset = 1'b1;
        i_valid = 1'b0;
        i_instr = 32'd0;
        alu_exp = '0;
        div_exp = '0;
        ill_exp = 1'b0;
        for (int i = 0; i < 32; i++)
            shadow[i] = 32'd0;
        repeat (3) @(posedge i_clock);
        @(negedge i_clock);
        i_reset = 1'b0;

        // Reset state and zero reads
        repeat (3) idle_cycle();
        for (int i = 0; i < N_RESET_READS; i++)
            issue_instr(encode_r(7'h00, 3'd0, 5'(i + 1), 5'($urandom), 5'($urandom)));
        end_test("reset");

        for (int r = 1; r < 32; r++)
            issue_instr(encode_i(12'($urandom), 3'd0, 5'(r), 5'd0));
        for (int i = 0; i < N_ALU_RANDOM; i++)
            issue_instr(random_alu_instr(5'd0));
        end_test("random ALU");

        for (int i = 0; i < N_RD_ZERO; i++)
            issue_instr(random_alu_instr(5'd0) & 32'hffff_f07f);  // rd forced to x0
        issue_instr(encode_r(7'h00, 3'd0, 5'd9, 5'd0, 5'd0));
        issue_instr(encode_i(12'd0, 3'd0, 5'd10, 5'd0));
        end_test("rd zero");

        issue_instr(encode_i(12'hfff, 3'd0, 5'd1, 5'd0));    // x1 = -1
        issue_instr(encode_i(12'd1, 3'd0, 5'd2, 5'd0));
        issue_instr(encode_i(12'd31, 3'd1, 5'd2, 5'd2));     // x2 = most negative
        issue_instr(encode_i(12'd0, 3'd0, 5'd3, 5'd0));      // x3 = 0
        for (int f = 4; f < 8; f++) begin
            drain_divider();
            issue_instr(encode_r(7'h01, 3'(f), 5'(f), 5'd2, 5'd1));
            drain_divider();
            issue_instr(encode_r(7'h01, 3'(f), 5'(f + 4), 5'd7, 5'd3));
        end
        for (int i = 0; i < N_DIV_RANDOM; i++) begin
            drain_divider();
            issue_instr(encode_r(7'h01, 3'(4 + $urandom % 4), 5'(1 + $urandom % 31),
                                 5'($urandom), 5'($urandom)));
        end
        drain_divider();
        end_test("divide");

        div_rd = 5'(1 + $urandom % 31);
        issue_instr(encode_r(7'h01, 3'(4 + $urandom % 4), div_rd, 5'($urandom), 5'($urandom)));
        for (int i = 0; i < N_B2B; i++)
            issue_instr(random_alu_instr(div_rd));
        drain_divider();
        end_test("divide under ALU traffic");

        issue_instr({20'h12345, 5'd10, 7'b0110111});         // LUI is not handled here
        idle_cycle();
        issue_instr(encode_r(7'h20, 3'd1, 5'd11, 5'd1, 5'd2));
        idle_cycle();
        issue_instr(encode_i({7'h20, 5'd3}, 3'd1, 5'd12, 5'd1));
        idle_cycle();
        end_test("illegal");

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule
